// ==== cachePkg.sv ====
package cachePkg;

  typedef logic [31:0] addrT;   // byte address
  typedef logic [31:0] wordT;
  typedef logic [7:0]  byteT;   // one RAM location
  typedef logic [1:0]  accessT; // access size of a data request

  localparam accessT ACC_NONE = 2'b00; // no request
  localparam accessT ACC_BYTE = 2'b01;
  localparam accessT ACC_HALF = 2'b10;
  localparam accessT ACC_WORD = 2'b11;

  // block transfer request from a cache to the memory controller
  typedef struct packed {
    logic request;
    logic write;     // 1 write-back, 0 refill
    addrT blockAddr; // low BLOCK_WIDTH bits zero
  } blockReqT;

  typedef enum logic [2:0] {
    MEM_IDLE,
    MEM_READ,  // issue refill addresses
    MEM_FILL,  // catch the last byte of a refill
    MEM_WRITE, // write-back, one byte per cycle
    MEM_DONE
  } memStateT;

  localparam int DEF_BLOCK_WIDTH  = 4;
  localparam int DEF_ICACHE_WIDTH = 2; // few lines so conflicts are easy to hit
  localparam int DEF_DCACHE_WIDTH = 2;

endpackage

// ==== burstCounter.sv ====
`timescale 1ns/1ps

module burstCounter #(
  parameter int BLOCK_WIDTH = cachePkg::DEF_BLOCK_WIDTH
) (
  input  logic                   clkIn,
  input  logic                   resetIn,
  input  logic                   countStart, // back to byte zero
  input  logic                   countEn,
  output logic [BLOCK_WIDTH-1:0] bytePos,
  output logic                   lastByte
);

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      bytePos <= '0;
    end else if (countStart) begin
      bytePos <= '0;
    end else if (countEn) begin
      bytePos <= bytePos + 1'b1; // wraps to zero after the last byte
    end
  end

  assign lastByte = &bytePos; // final byte of the block

endmodule

// ==== lineBuffer.sv ====
`timescale 1ns/1ps

module lineBuffer #(
  parameter  int BLOCK_WIDTH = cachePkg::DEF_BLOCK_WIDTH,
  localparam int BLOCK_BITS  = 8 << BLOCK_WIDTH
) (
  input  logic                   clkIn,
  input  logic                   loadBlock, // take the victim block whole
  input  logic [BLOCK_BITS-1:0]  wbData,
  input  logic                   shiftIn,   // memIn holds a refill byte
  input  logic [BLOCK_WIDTH-1:0] writePos,
  input  logic [BLOCK_WIDTH-1:0] readPos,
  input  cachePkg::byteT         memIn,
  output cachePkg::byteT         outByte,
  output logic [BLOCK_BITS-1:0]  fillData
);

  logic [BLOCK_BITS-1:0] block;

  always_ff @(posedge clkIn) begin
    if (loadBlock) begin
      block <= wbData;
    end else if (shiftIn) begin
      block[{writePos, 3'b000} +: 8] <= memIn; // writePos trails the address
    end
  end

  assign outByte  = block[{readPos, 3'b000} +: 8]; // write-back byte
  assign fillData = block;

endmodule

// ==== memCtrlFsm.sv ====
`timescale 1ns/1ps

module memCtrlFsm #(
  parameter int BLOCK_WIDTH = cachePkg::DEF_BLOCK_WIDTH
) (
  input  logic                   clkIn,
  input  logic                   resetIn,
  input  cachePkg::blockReqT     iReq,
  input  cachePkg::blockReqT     dReq,
  input  logic [BLOCK_WIDTH-1:0] bytePos,
  input  logic                   lastByte,
  output logic                   countStart,
  output logic                   countEn,
  output logic                   loadBlock,
  output logic                   shiftIn,
  output logic [BLOCK_WIDTH-1:0] fillPos,
  output cachePkg::addrT         memAddr,
  output logic                   readWriteOut, // 1 = write
  output logic                   iDone,
  output logic                   dDone
);
  import cachePkg::*;

  memStateT                state;
  memStateT                nextState;
  blockReqT                grantReq;
  logic                    grant;
  logic                    ownerData; // dCache owns the transfer
  logic                    readLag;   // last cycle issued a refill address
  logic [31-BLOCK_WIDTH:0] blockTag;

  assign grantReq = dReq.request ? dReq : iReq; // data misses first
  assign grant    = (state == MEM_IDLE) && grantReq.request;

  always_comb begin
    nextState = state;
    case (state)
      MEM_IDLE: begin
        if (grantReq.request) begin
          nextState = grantReq.write ? MEM_WRITE : MEM_READ;
        end
      end
      MEM_READ: begin
        if (lastByte) begin
          nextState = MEM_FILL; // one more cycle for RAM latency
        end
      end
      MEM_FILL: begin
        nextState = MEM_DONE;
      end
      MEM_WRITE: begin
        if (lastByte) begin
          nextState = MEM_DONE;
        end
      end
      default: begin
        nextState = MEM_IDLE;
      end
    endcase
  end

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      state     <= MEM_IDLE;
      ownerData <= 1'b0;
      readLag   <= 1'b0;
    end else begin
      state   <= nextState;
      readLag <= (state == MEM_READ);
      if (grant) begin
        ownerData <= dReq.request;
      end
    end
  end

  always_ff @(posedge clkIn) begin
    fillPos <= bytePos; // byte arriving now was addressed last cycle
    if (grant) begin
      blockTag <= grantReq.blockAddr[31:BLOCK_WIDTH];
    end
  end

  assign countStart   = grant;
  assign countEn      = (state == MEM_READ) || (state == MEM_WRITE);
  assign loadBlock    = grant && grantReq.write;
  assign shiftIn      = readLag;
  assign memAddr      = {blockTag, bytePos};
  assign readWriteOut = (state == MEM_WRITE); // back to read once the burst ends
  assign iDone        = (state == MEM_DONE) && !ownerData;
  assign dDone        = (state == MEM_DONE) && ownerData;

endmodule

// ==== iCache.sv ====
`timescale 1ns/1ps

module iCache #(
  parameter  int BLOCK_WIDTH  = cachePkg::DEF_BLOCK_WIDTH,
  parameter  int ICACHE_WIDTH = cachePkg::DEF_ICACHE_WIDTH,
  localparam int BLOCK_BITS   = 8 << BLOCK_WIDTH
) (
  input  logic                  clkIn,
  input  logic                  resetIn,
  input  logic                  instrReq,
  input  cachePkg::addrT        instrAddrIn,
  input  logic                  iDone,
  input  logic [BLOCK_BITS-1:0] fillData,
  output cachePkg::blockReqT    iReq,
  output logic                  instrOutValid,
  output cachePkg::wordT        instrOut
);

  localparam int LINES     = 1 << ICACHE_WIDTH;
  localparam int TAG_WIDTH = 32 - BLOCK_WIDTH - ICACHE_WIDTH;

  logic [TAG_WIDTH-1:0]    tagArr  [LINES];
  logic [BLOCK_BITS-1:0]   dataArr [LINES];
  logic [LINES-1:0]        validArr;
  logic [TAG_WIDTH-1:0]    tag;
  logic [ICACHE_WIDTH-1:0] index;
  logic [BLOCK_WIDTH-3:0]  wordSel;
  logic                    hit;

  assign tag     = instrAddrIn[31 -: TAG_WIDTH];
  assign index   = instrAddrIn[BLOCK_WIDTH +: ICACHE_WIDTH];
  assign wordSel = instrAddrIn[BLOCK_WIDTH-1:2];
  assign hit     = validArr[index] && (tagArr[index] == tag);

  // refill request drops by itself once the line is written
  always_comb begin
    iReq.request   = instrReq && !hit;
    iReq.write     = 1'b0; // never dirty
    iReq.blockAddr = {instrAddrIn[31:BLOCK_WIDTH], {BLOCK_WIDTH{1'b0}}};
  end

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      validArr      <= '0;
      instrOutValid <= 1'b0;
    end else begin
      instrOutValid <= instrReq && hit && !instrOutValid; // one pulse per request
      if (iDone) begin
        validArr[index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clkIn) begin
    if (iDone) begin
      tagArr[index]  <= tag;
      dataArr[index] <= fillData;
    end
    if (instrReq && hit) begin
      instrOut <= dataArr[index][{wordSel, 5'b00000} +: 32];
    end
  end

endmodule

// ==== dCache.sv ====
`timescale 1ns/1ps

module dCache #(
  parameter  int BLOCK_WIDTH  = cachePkg::DEF_BLOCK_WIDTH,
  parameter  int DCACHE_WIDTH = cachePkg::DEF_DCACHE_WIDTH,
  localparam int BLOCK_BITS   = 8 << BLOCK_WIDTH
) (
  input  logic                  clkIn,
  input  logic                  resetIn,
  input  cachePkg::accessT      accessType,
  input  logic                  readWriteIn, // 1 = load
  input  cachePkg::addrT        dataAddrIn,
  input  cachePkg::wordT        dataIn,
  input  logic                  dDone,
  input  logic [BLOCK_BITS-1:0] fillData,
  output cachePkg::blockReqT    dReq,
  output logic [BLOCK_BITS-1:0] wbData,
  output logic                  dataOutValid,
  output cachePkg::wordT        dataOut,
  output logic                  dataWriteSuc
);
  import cachePkg::*;

  localparam int LINES     = 1 << DCACHE_WIDTH;
  localparam int TAG_WIDTH = 32 - BLOCK_WIDTH - DCACHE_WIDTH;

  logic [TAG_WIDTH-1:0]    tagArr  [LINES];
  logic [BLOCK_BITS-1:0]   dataArr [LINES];
  logic [LINES-1:0]        validArr;
  logic [LINES-1:0]        dirtyArr;
  logic [TAG_WIDTH-1:0]    tag;
  logic [DCACHE_WIDTH-1:0] index;
  logic [BLOCK_WIDTH+2:0]  bitOffset;
  logic                    active;
  logic                    hit;
  logic                    victimDirty;
  logic                    respond;
  logic                    doneHold; // keeps the request low after a done
  wordT                    sizeMask;
  wordT                    loadWord;
  logic [BLOCK_BITS-1:0]   curLine;
  logic [BLOCK_BITS-1:0]   lineShift;
  logic [BLOCK_BITS-1:0]   storeMask;
  logic [BLOCK_BITS-1:0]   mergedLine;

  assign tag         = dataAddrIn[31 -: TAG_WIDTH];
  assign index       = dataAddrIn[BLOCK_WIDTH +: DCACHE_WIDTH];
  assign bitOffset   = {dataAddrIn[BLOCK_WIDTH-1:0], 3'b000};
  assign active      = (accessType != ACC_NONE);
  assign curLine     = dataArr[index];
  assign hit         = validArr[index] && (tagArr[index] == tag);
  assign victimDirty = validArr[index] && dirtyArr[index] && !hit;
  assign respond     = active && hit && !dataOutValid && !dataWriteSuc;
  assign wbData      = curLine;

  // dirty victim goes out first, refill follows on the next request
  always_comb begin
    dReq.request = active && !hit && !doneHold;
    dReq.write   = victimDirty;
    if (victimDirty) begin
      dReq.blockAddr = {tagArr[index], index, {BLOCK_WIDTH{1'b0}}};
    end else begin
      dReq.blockAddr = {tag, index, {BLOCK_WIDTH{1'b0}}};
    end
  end

  always_comb begin
    case (accessType)
      ACC_BYTE: sizeMask = 32'h0000_00ff;
      ACC_HALF: sizeMask = 32'h0000_ffff;
      ACC_WORD: sizeMask = 32'hffff_ffff;
      default:  sizeMask = '0;
    endcase
  end

  assign lineShift  = curLine >> bitOffset;
  assign loadWord   = lineShift[31:0] & sizeMask; // zero-extended
  assign storeMask  = BLOCK_BITS'(sizeMask) << bitOffset;
  assign mergedLine = (curLine & ~storeMask) | (BLOCK_BITS'(dataIn & sizeMask) << bitOffset);

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      validArr     <= '0;
      dirtyArr     <= '0;
      dataOutValid <= 1'b0;
      dataWriteSuc <= 1'b0;
      doneHold     <= 1'b0;
    end else begin
      dataOutValid <= respond && readWriteIn;
      dataWriteSuc <= respond && !readWriteIn;
      doneHold     <= dDone;
      if (dDone) begin
        dirtyArr[index] <= 1'b0; // clean after write-back or refill
        if (!victimDirty) begin
          validArr[index] <= 1'b1;
        end
      end else if (respond && !readWriteIn) begin
        dirtyArr[index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clkIn) begin
    if (dDone && !victimDirty) begin
      tagArr[index]  <= tag;
      dataArr[index] <= fillData;
    end else if (respond && !readWriteIn) begin
      dataArr[index] <= mergedLine;
    end
    if (respond && readWriteIn) begin
      dataOut <= loadWord;
    end
  end

endmodule

// ==== cacheTop.sv ====
`timescale 1ns/1ps

module cacheTop #(
  parameter int BLOCK_WIDTH  = cachePkg::DEF_BLOCK_WIDTH,
  parameter int ICACHE_WIDTH = cachePkg::DEF_ICACHE_WIDTH,
  parameter int DCACHE_WIDTH = cachePkg::DEF_DCACHE_WIDTH
) (
  input  logic             clkIn,
  input  logic             resetIn,
  input  logic             instrReq,
  input  cachePkg::addrT   instrAddrIn,
  input  cachePkg::accessT accessType,
  input  logic             readWriteIn,  // 1 = read
  input  cachePkg::addrT   dataAddrIn,
  input  cachePkg::wordT   dataIn,
  input  cachePkg::byteT   memIn,
  output logic             readWriteOut, // 1 = write
  output cachePkg::addrT   memAddr,
  output cachePkg::byteT   memOut,
  output logic             instrOutValid,
  output cachePkg::wordT   instrOut,
  output logic             dataOutValid,
  output cachePkg::wordT   dataOut,
  output logic             dataWriteSuc
);
  import cachePkg::*;

  localparam int BLOCK_BITS = 8 << BLOCK_WIDTH;

  blockReqT               iReq;
  blockReqT               dReq;
  logic [BLOCK_BITS-1:0]  wbData;
  logic [BLOCK_BITS-1:0]  fillData;
  logic                   iDone;
  logic                   dDone;
  logic                   countStart;
  logic                   countEn;
  logic                   lastByte;
  logic                   loadBlock;
  logic                   shiftIn;
  logic [BLOCK_WIDTH-1:0] bytePos;
  logic [BLOCK_WIDTH-1:0] fillPos;

  iCache #(
    .BLOCK_WIDTH  (BLOCK_WIDTH),
    .ICACHE_WIDTH (ICACHE_WIDTH)
  ) i_iCache (
    .clkIn         (clkIn),
    .resetIn       (resetIn),
    .instrReq      (instrReq),
    .instrAddrIn   (instrAddrIn),
    .iDone         (iDone),
    .fillData      (fillData),
    .iReq          (iReq),
    .instrOutValid (instrOutValid),
    .instrOut      (instrOut)
  );

  dCache #(
    .BLOCK_WIDTH  (BLOCK_WIDTH),
    .DCACHE_WIDTH (DCACHE_WIDTH)
  ) i_dCache (
    .clkIn        (clkIn),
    .resetIn      (resetIn),
    .accessType   (accessType),
    .readWriteIn  (readWriteIn),
    .dataAddrIn   (dataAddrIn),
    .dataIn       (dataIn),
    .dDone        (dDone),
    .fillData     (fillData),
    .dReq         (dReq),
    .wbData       (wbData),
    .dataOutValid (dataOutValid),
    .dataOut      (dataOut),
    .dataWriteSuc (dataWriteSuc)
  );

  memCtrlFsm #(
    .BLOCK_WIDTH (BLOCK_WIDTH)
  ) i_memCtrlFsm (
    .clkIn        (clkIn),
    .resetIn      (resetIn),
    .iReq         (iReq),
    .dReq         (dReq),
    .bytePos      (bytePos),
    .lastByte     (lastByte),
    .countStart   (countStart),
    .countEn      (countEn),
    .loadBlock    (loadBlock),
    .shiftIn      (shiftIn),
    .fillPos      (fillPos),
    .memAddr      (memAddr),
    .readWriteOut (readWriteOut),
    .iDone        (iDone),
    .dDone        (dDone)
  );

  burstCounter #(
    .BLOCK_WIDTH (BLOCK_WIDTH)
  ) i_burstCounter (
    .clkIn      (clkIn),
    .resetIn    (resetIn),
    .countStart (countStart),
    .countEn    (countEn),
    .bytePos    (bytePos),
    .lastByte   (lastByte)
  );

  lineBuffer #(
    .BLOCK_WIDTH (BLOCK_WIDTH)
  ) i_lineBuffer (
    .clkIn     (clkIn),
    .loadBlock (loadBlock),
    .wbData    (wbData),
    .shiftIn   (shiftIn),
    .writePos  (fillPos),
    .readPos   (bytePos), // write-back byte follows the address
    .memIn     (memIn),
    .outByte   (memOut),
    .fillData  (fillData)
  );

endmodule

// ==== cacheTb_assert.sv ====
`timescale 1ns/1ps

module cacheTbAssert (
  input logic               clkIn,
  input logic               resetIn,
  input cachePkg::memStateT state,
  input logic               readWriteOut,
  input logic               iDone,
  input logic               dDone
);
  import cachePkg::*;

  int failCount = 0; // failed assertions so far

  oneOwner: assert property (@(posedge clkIn) disable iff (resetIn) !(iDone && dDone))
    else begin
      $error("iDone and dDone high in the same cycle");
      failCount++;
    end

  iDonePulse: assert property (@(posedge clkIn) disable iff (resetIn) iDone |=> !iDone)
    else begin
      $error("iDone held longer than one cycle");
      failCount++;
    end

  dDonePulse: assert property (@(posedge clkIn) disable iff (resetIn) dDone |=> !dDone)
    else begin
      $error("dDone held longer than one cycle");
      failCount++;
    end

  writeOnlyInBurst: assert property (@(posedge clkIn) disable iff (resetIn)
    readWriteOut |-> (state == MEM_WRITE))
    else begin
      $error("RAM write strobe outside MEM_WRITE");
      failCount++;
    end

  noDoneInIdle: assert property (@(posedge clkIn) disable iff (resetIn)
    (state == MEM_IDLE) |-> !(iDone || dDone))
    else begin
      $error("done pulse while the controller is idle");
      failCount++;
    end

endmodule

bind memCtrlFsm cacheTbAssert i_assert (
  .clkIn        (clkIn),
  .resetIn      (resetIn),
  .state        (state),
  .readWriteOut (readWriteOut),
  .iDone        (iDone),
  .dDone        (dDone)
);

// ==== cacheTb.sv ====
`timescale 1ns/1ps

module cacheTb;
  import cachePkg::*;

  localparam int TIMEOUT = 200; // cycles allowed per request

  logic   clkIn;
  logic   resetIn;
  logic   instrReq;
  addrT   instrAddrIn;
  accessT accessType;
  logic   readWriteIn; // 1 = load
  addrT   dataAddrIn;
  wordT   dataIn;
  byteT   memIn;
  logic   readWriteOut;
  addrT   memAddr;
  byteT   memOut;
  logic   instrOutValid;
  wordT   instrOut;
  logic   dataOutValid;
  wordT   dataOut;
  logic   dataWriteSuc;

  byteT   ram    [4096]; // RAM behind the DUT
  byteT   shadow [4096]; // reference memory
  wordT   expData[$];    // pending load results
  wordT   expInstr[$];
  string  curTest;
  int     seed;
  int     errors;
  int     checks;
  int     tests;

  cacheTop i_dut (.*);

  always #50 clkIn = ~clkIn;

  // byte RAM with one cycle read latency
  always @(posedge clkIn) begin
    if (readWriteOut === 1'b1) begin
      ram[memAddr[11:0]] <= memOut;
    end
    memIn <= ram[memAddr[11:0]];
  end

  // each response against the value queued when it was issued
  always @(posedge clkIn) begin
    if (dataOutValid === 1'b1) begin
      if (expData.size() == 0) begin
        errors++;
        $display("data response arrived with no load pending in test %s", curTest);
      end else begin
        checkVal(curTest, expData.pop_front(), dataOut);
      end
    end
    if (instrOutValid === 1'b1) begin
      if (expInstr.size() == 0) begin
        errors++;
        $display("instruction response arrived with no fetch pending in test %s", curTest);
      end else begin
        checkVal(curTest, expInstr.pop_front(), instrOut);
      end
    end
  end

  // little-endian, zero-extended
  function automatic wordT refLoad(input addrT addr, input accessT size);
    wordT val;
    int   nBytes;
    val    = '0;
    nBytes = (size == ACC_BYTE) ? 1 : (size == ACC_HALF) ? 2 : 4;
    for (int k = 0; k < nBytes; k++) begin
      val[8*k +: 8] = shadow[addr[11:0] + k];
    end
    return val;
  endfunction

  function automatic void storeShadow(input addrT addr, input accessT size, input wordT data);
    int nBytes;
    nBytes = (size == ACC_BYTE) ? 1 : (size == ACC_HALF) ? 2 : 4;
    for (int k = 0; k < nBytes; k++) begin
      shadow[addr[11:0] + k] = data[8*k +: 8];
    end
  endfunction

  function automatic wordT ramWord(input addrT addr);
    return {ram[addr[11:0] + 3], ram[addr[11:0] + 2], ram[addr[11:0] + 1], ram[addr[11:0]]};
  endfunction

  task automatic checkVal(input string name, input wordT expected, input wordT actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic endTest();
    repeat (2) @(posedge clkIn); // let the last response drain
    tests++;
    $display("test %s finished, %0d errors so far", curTest, errors);
  endtask

  task automatic dataAccess(input logic load, input accessT size, input addrT addr,
                            input wordT wdata);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    if (load) begin
      expData.push_back(refLoad(addr, size));
    end else begin
      storeShadow(addr, size, wdata);
    end
    @(posedge clkIn);
    accessType  <= size;
    readWriteIn <= load;
    dataAddrIn  <= addr;
    dataIn      <= wdata;
    while (!seen && cycles < TIMEOUT) begin
      @(posedge clkIn);
      cycles++;
      seen = (dataOutValid === 1'b1) || (dataWriteSuc === 1'b1);
    end
    accessType <= ACC_NONE;
    if (!seen) begin
      abortRun($sformatf("no data response within %0d cycles at address %h", TIMEOUT, addr));
    end else begin
      checkVal({curTest, " response kind"}, 32'(load), 32'(dataOutValid));
    end
  endtask

  task automatic fetch(input addrT addr, output int cycles);
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    expInstr.push_back(refLoad(addr, ACC_WORD));
    @(posedge clkIn);
    instrReq    <= 1'b1;
    instrAddrIn <= addr;
    while (!seen && cycles < TIMEOUT) begin
      @(posedge clkIn);
      cycles++;
      seen = (instrOutValid === 1'b1);
    end
    instrReq <= 1'b0;
    if (!seen) begin
      abortRun($sformatf("no instruction within %0d cycles at address %h", TIMEOUT, addr));
    end
  endtask

  // both misses raised on the same edge
  task automatic fetchAndLoad(input addrT iAddr, input addrT dAddr);
    int   cycles;
    logic iSeen;
    logic dSeen;
    cycles = 0;
    iSeen  = 1'b0;
    dSeen  = 1'b0;
    expInstr.push_back(refLoad(iAddr, ACC_WORD));
    expData.push_back(refLoad(dAddr, ACC_WORD));
    @(posedge clkIn);
    instrReq    <= 1'b1;
    instrAddrIn <= iAddr;
    accessType  <= ACC_WORD;
    readWriteIn <= 1'b1;
    dataAddrIn  <= dAddr;
    while (!(iSeen && dSeen) && cycles < TIMEOUT) begin
      @(posedge clkIn);
      cycles++;
      if (instrOutValid === 1'b1) begin
        iSeen = 1'b1;
        instrReq <= 1'b0;
      end
      if (dataOutValid === 1'b1) begin
        dSeen = 1'b1;
        accessType <= ACC_NONE;
      end
    end
    if (!(iSeen && dSeen)) begin
      abortRun("instruction and data requests did not both complete in time");
    end
  endtask

  initial begin : mainFlow
    int     cycles;
    wordT   raw;
    addrT   addr;
    accessT size;
    seed        = 92;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    clkIn       = 1'b0;
    resetIn     = 1'b1;
    instrReq    = 1'b0;
    instrAddrIn = '0;
    accessType  = ACC_NONE;
    readWriteIn = 1'b1;
    dataAddrIn  = '0;
    dataIn      = '0;
    memIn       = '0;
    for (int i = 0; i < 4096; i++) begin
      ram[i]    = $random(seed);
      shadow[i] = ram[i];
    end
    repeat (4) @(posedge clkIn);
    resetIn <= 1'b0;

    curTest = "reset";
    for (int i = 0; i < 6; i++) begin
      @(posedge clkIn);
      checkVal(curTest, 0, {28'd0, instrOutValid, dataOutValid, dataWriteSuc, readWriteOut});
    end
    endTest();

    curTest = "fetch";
    fetch(32'h820, cycles); // miss
    fetch(32'h820, cycles);
    checkVal("fetch hit latency", 2, cycles);
    fetch(32'h82c, cycles);
    checkVal("fetch hit latency", 2, cycles);
    endTest();

    curTest = "data sizes";
    dataAccess(1'b1, ACC_BYTE, 32'h041, '0);
    dataAccess(1'b1, ACC_BYTE, 32'h043, '0);
    dataAccess(1'b1, ACC_HALF, 32'h042, '0);
    dataAccess(1'b1, ACC_HALF, 32'h04e, '0);
    dataAccess(1'b1, ACC_WORD, 32'h044, '0);
    dataAccess(1'b0, ACC_BYTE, 32'h049, 32'h0000_00a5);
    dataAccess(1'b0, ACC_HALF, 32'h04a, 32'h0000_beef);
    dataAccess(1'b1, ACC_WORD, 32'h048, '0);
    dataAccess(1'b0, ACC_BYTE, 32'h04c, 32'h1234_563c); // upper bytes must not land
    dataAccess(1'b1, ACC_WORD, 32'h04c, '0);
    endTest();

    curTest = "eviction";
    dataAccess(1'b0, ACC_WORD, 32'h100, 32'hcafe_f00d);
    dataAccess(1'b1, ACC_WORD, 32'h140, '0); // same index, pushes 0x100 out
    checkVal("eviction ram", 32'hcafe_f00d, ramWord(32'h100));
    dataAccess(1'b1, ACC_WORD, 32'h180, '0);
    dataAccess(1'b1, ACC_WORD, 32'h100, '0);
    endTest();

    curTest = "overlap";
    fetchAndLoad(32'h900, 32'h0f4);
    endTest();

    curTest = "random";
    for (int n = 0; n < 200; n++) begin
      raw  = $random(seed);
      size = (raw[1:0] == 2'b00) ? ACC_WORD : accessT'(raw[1:0]);
      addr = {23'd0, raw[12:4]}; // small region, many conflicts
      if (size == ACC_HALF) begin
        addr[0] = 1'b0;
      end
      if (size == ACC_WORD) begin
        addr[1:0] = 2'b00;
      end
      dataAccess(raw[20], size, addr, $random(seed));
      if (n % 5 == 0) begin
        fetch(32'h800 + ($random(seed) & 32'h7fc), cycles);
      end
    end
    endTest();

    checkVal("assertions", 0, i_dut.i_memCtrlFsm.i_assert.failCount);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
cachePkg.sv
burstCounter.sv
lineBuffer.sv
memCtrlFsm.sv
iCache.sv
dCache.sv
cacheTop.sv
cacheTb_assert.sv
cacheTb.sv
